//--- include/axi_mem_cfg.svh
// Bridge widths and depths; every beat is full bus width and all addresses are word aligned.
`ifndef AXI_MEM_CFG_SVH
`define AXI_MEM_CFG_SVH

// Byte address width of the AXI side and of the memory port.
`define AXM_ADDR_W 16

// Data bus width in bits.
// Must be a multiple of 8, one strobe bit per byte.
`define AXM_DATA_W 32

// Transaction ID width, shared by AR, AW, R and B.
`define AXM_ID_W 4

// Burst length field width.
// The field holds beats minus one, so 8 bits give up to 256 beats.
`define AXM_LEN_W 8

// Memory accesses in flight plus buffered replies.
// Should cover the memory read latency for full throughput.
`define AXM_BUF_DEPTH 2

`endif

//--- logic/axi_mem_pkg.sv
// Shared bridge types; widths are taken from the cfg header, response codes follow AXI.
`include "axi_mem_cfg.svh"

package axi_mem_pkg;

  // Byte address on the AXI side and at the memory port.
  typedef logic [`AXM_ADDR_W-1:0] addr_t;

  // One full-width data word.
  typedef logic [`AXM_DATA_W-1:0] data_t;

  // Byte enables, one per byte lane.
  typedef logic [`AXM_DATA_W/8-1:0] strb_t;

  // Transaction ID.
  typedef logic [`AXM_ID_W-1:0] id_t;

  // Burst length as beats minus one.
  typedef logic [`AXM_LEN_W-1:0] len_t;

  // R and B response codes.
  // Only OKAY and SLVERR are ever returned.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_t;

  // Per-access record kept while the memory works on it.
  typedef struct packed {
    id_t  id;
    logic last;
    logic write;
  } beat_meta_t;

  // One memory reply with its error flag.
  typedef struct packed {
    data_t data;
    logic  err;
  } mem_rsp_t;

endpackage

//--- logic/mem_beat_if.sv
// One memory beat with valid/ready; payload must hold while valid is high and ready low.
`timescale 1ns/1ps

interface mem_beat_if
  import axi_mem_pkg::*;
();

  // Handshake pair.
  logic  valid;
  logic  ready;

  // Beat payload.
  // The walker fills wdata and strb only for writes.
  addr_t addr;
  data_t wdata;
  strb_t strb;
  logic  we;
  id_t   id;
  logic  last;

  // Producer side.
  modport src (output valid, addr, wdata, strb, we, id, last, input ready);

  // Consumer side.
  modport dst (input valid, addr, wdata, strb, we, id, last, output ready);

endinterface

//--- logic/sync_fifo.sv
// Fall-through FIFO; empty_o low already in the push cycle, pushes while full are dropped.
`timescale 1ns/1ps

module sync_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic push_i,
  input  T     data_i,
  output logic full_o,
  input  logic pop_i,
  output T     data_o,
  output logic empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W:0]   cnt_q;
  logic             stored_none;
  logic             do_push;
  logic             do_pop;

  assign stored_none = (cnt_q == '0);
  assign full_o      = (cnt_q == (PTR_W + 1)'(DEPTH));
  // Input shows through while nothing is stored.
  assign empty_o     = stored_none && !push_i;
  assign data_o      = stored_none ? data_i : mem_q[rd_ptr_q];

  // A word that falls straight through is never written.
  assign do_push = push_i && !full_o && !(stored_none && pop_i);
  assign do_pop  = pop_i && !stored_none;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      end
      cnt_q <= cnt_q + (PTR_W + 1)'(do_push) - (PTR_W + 1)'(do_pop);
    end
  end

  // Storage.
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- logic/burst_walker.sv
// INCR bursts only; the first beat leaves in the request cycle, a write beat waits on W data.
`timescale 1ns/1ps
`include "axi_mem_cfg.svh"

module burst_walker
  import axi_mem_pkg::*;
#(
  parameter bit IS_WRITE = 1'b0
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  req_valid_i,
  output logic  req_ready_o,
  input  addr_t req_addr_i,
  input  id_t   req_id_i,
  input  len_t  req_len_i,
  input  logic  w_valid_i,
  output logic  w_ready_o,
  input  data_t w_data_i,
  input  strb_t w_strb_i,
  output logic  busy_o,
  mem_beat_if.src beat
);

  // Addresses advance one word per beat and start on a word boundary.
  localparam addr_t WORD_INC   = addr_t'(`AXM_DATA_W / 8);
  localparam addr_t ALIGN_MASK = ~addr_t'(`AXM_DATA_W / 8 - 1);

  // Beats still to come after the one already issued.
  len_t  cnt_q;
  // Address of the next beat in the burst.
  addr_t addr_q;
  id_t   id_q;
  logic  fire;

  assign busy_o = (cnt_q != '0);

  // Write beats only exist while W data is present.
  assign beat.valid = (busy_o || req_valid_i) && (!IS_WRITE || w_valid_i);
  assign beat.addr  = busy_o ? addr_q : (req_addr_i & ALIGN_MASK);
  assign beat.id    = busy_o ? id_q : req_id_i;
  assign beat.last  = busy_o ? (cnt_q == len_t'(1)) : (req_len_i == '0);
  assign beat.we    = IS_WRITE;
  assign beat.wdata = w_data_i;
  assign beat.strb  = IS_WRITE ? w_strb_i : '0;

  assign fire = beat.valid && beat.ready;

  // Address channel handshake only on the first beat.
  assign req_ready_o = fire && !busy_o;
  assign w_ready_o   = IS_WRITE && fire;

  // Remaining-beat counter.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (fire) begin
      cnt_q <= busy_o ? cnt_q - len_t'(1) : req_len_i;
    end
  end

  // Next address and ID of the running burst.
  always_ff @(posedge clk_i) begin
    if (fire) begin
      addr_q <= beat.addr + WORD_INC;
      if (!busy_o) begin
        id_q <= req_id_i;
      end
    end
  end

endmodule

//--- logic/beat_arbiter.sv
// Read/write beat arbiter; the choice is combinational and held while the output stalls.
`timescale 1ns/1ps

module beat_arbiter
  import axi_mem_pkg::*;
(
  input  logic clk_i,
  input  logic arst_n_i,
  mem_beat_if.dst rd_beat,
  mem_beat_if.dst wr_beat,
  input  logic rd_busy_i,
  input  logic wr_busy_i,
  mem_beat_if.src sel_beat
);

  // Selection, 1 picks the write side.
  logic sel_d;
  logic sel_q;
  // Set while a presented beat waits for ready.
  logic lock_d;
  logic lock_q;

  always_comb begin
    sel_d = sel_q;
    if (lock_q) begin
      // Keep the stalled beat on the output.
      sel_d = sel_q;
    end else if (rd_beat.valid ^ wr_beat.valid) begin
      // Only one side wants the port.
      sel_d = wr_beat.valid;
    end else if (rd_beat.valid && wr_beat.valid) begin
      if (wr_beat.last && !rd_beat.last) begin
        // Single-beat write beats a read burst.
        sel_d = 1'b1;
      end else if (wr_busy_i) begin
        // Running write burst goes first.
        sel_d = 1'b1;
      end else if (rd_busy_i) begin
        // Then a running read burst.
        sel_d = 1'b0;
      end else begin
        // Round robin against starvation.
        sel_d = ~sel_q;
      end
    end
  end

  // Output mux.
  assign sel_beat.valid = sel_d ? wr_beat.valid : rd_beat.valid;
  assign sel_beat.addr  = sel_d ? wr_beat.addr  : rd_beat.addr;
  assign sel_beat.wdata = sel_d ? wr_beat.wdata : rd_beat.wdata;
  assign sel_beat.strb  = sel_d ? wr_beat.strb  : rd_beat.strb;
  assign sel_beat.we    = sel_d ? wr_beat.we    : rd_beat.we;
  assign sel_beat.id    = sel_d ? wr_beat.id    : rd_beat.id;
  assign sel_beat.last  = sel_d ? wr_beat.last  : rd_beat.last;

  // Ready goes back to the chosen side only.
  assign rd_beat.ready = !sel_d && sel_beat.ready;
  assign wr_beat.ready = sel_d && sel_beat.ready;

  // Lock until the waiting beat is taken.
  assign lock_d = sel_beat.valid && !sel_beat.ready;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel_q  <= 1'b0;
      lock_q <= 1'b0;
    end else begin
      sel_q  <= sel_d;
      lock_q <= lock_d;
    end
  end

endmodule

//--- logic/resp_router.sv
// Memory issue and reply routing; the memory must answer every granted access once, in order.
`timescale 1ns/1ps
`include "axi_mem_cfg.svh"

module resp_router
  import axi_mem_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  mem_beat_if.dst sel_beat,
  output logic  mem_req_o,
  input  logic  mem_gnt_i,
  output addr_t mem_addr_o,
  output data_t mem_wdata_o,
  output strb_t mem_strb_o,
  output logic  mem_we_o,
  input  logic  mem_rvalid_i,
  input  data_t mem_rdata_i,
  input  logic  mem_err_i,
  output logic  r_valid_o,
  input  logic  r_ready_i,
  output data_t r_data_o,
  output id_t   r_id_o,
  output resp_t r_resp_o,
  output logic  r_last_o,
  output logic  b_valid_o,
  input  logic  b_ready_i,
  output id_t   b_id_o,
  output resp_t b_resp_o
);

  localparam int unsigned CRED_W = $clog2(`AXM_BUF_DEPTH + 1);

  // Accesses in flight plus replies not yet delivered.
  logic [CRED_W-1:0] used_q;
  logic              credit_ok;
  logic              issue;
  beat_meta_t        meta_in;
  beat_meta_t        meta_head;
  logic              meta_empty;
  logic              meta_full;
  mem_rsp_t          rsp_in;
  mem_rsp_t          rsp_head;
  logic              rsp_empty;
  logic              both;
  logic              resp_pop;

  // Issue side.
  assign credit_ok      = (used_q < CRED_W'(`AXM_BUF_DEPTH)) && !meta_full;
  assign mem_req_o      = sel_beat.valid && credit_ok;
  assign sel_beat.ready = credit_ok && mem_gnt_i;
  assign issue          = mem_req_o && mem_gnt_i;
  assign mem_addr_o     = sel_beat.addr;
  assign mem_wdata_o    = sel_beat.wdata;
  assign mem_strb_o     = sel_beat.strb;
  assign mem_we_o       = sel_beat.we;

  assign meta_in = '{id: sel_beat.id, last: sel_beat.last, write: sel_beat.we};
  assign rsp_in  = '{data: mem_rdata_i, err: mem_err_i};

  // Remembers who asked, one entry per granted access.
  sync_fifo #(.T(beat_meta_t), .DEPTH(`AXM_BUF_DEPTH)) u_meta_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (issue),
    .data_i   (meta_in),
    .full_o   (meta_full),
    .pop_i    (resp_pop),
    .data_o   (meta_head),
    .empty_o  (meta_empty)
  );

  // Holds replies while R or B is stalled.
  sync_fifo #(.T(mem_rsp_t), .DEPTH(`AXM_BUF_DEPTH)) u_data_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .push_i   (mem_rvalid_i),
    .data_i   (rsp_in),
    .full_o   (),
    .pop_i    (resp_pop),
    .data_o   (rsp_head),
    .empty_o  (rsp_empty)
  );

  // Route the joined heads.
  // Non-last write beats leave without a response.
  assign both      = !meta_empty && !rsp_empty;
  assign r_valid_o = both && !meta_head.write;
  assign b_valid_o = both && meta_head.write && meta_head.last;
  assign resp_pop  = both && (r_valid_o ? r_ready_i : (b_valid_o ? b_ready_i : 1'b1));

  assign r_data_o = rsp_head.data;
  assign r_id_o   = meta_head.id;
  assign r_last_o = meta_head.last;
  assign r_resp_o = rsp_head.err ? RESP_SLVERR : RESP_OKAY;
  assign b_id_o   = meta_head.id;
  assign b_resp_o = rsp_head.err ? RESP_SLVERR : RESP_OKAY;

  // Credit returns only when the response leaves.
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      used_q <= '0;
    end else begin
      used_q <= used_q + CRED_W'(issue) - CRED_W'(resp_pop);
    end
  end

endmodule

//--- logic/axi_mem_bridge.sv
// AXI-style burst slave onto one in-order memory port; INCR, full-width beats, no narrow.
`timescale 1ns/1ps

module axi_mem_bridge
  import axi_mem_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  // Read address channel.
  input  logic  ar_valid_i,
  output logic  ar_ready_o,
  input  addr_t ar_addr_i,
  input  id_t   ar_id_i,
  input  len_t  ar_len_i,
  // Write address channel.
  input  logic  aw_valid_i,
  output logic  aw_ready_o,
  input  addr_t aw_addr_i,
  input  id_t   aw_id_i,
  input  len_t  aw_len_i,
  // Write data channel.
  input  logic  w_valid_i,
  output logic  w_ready_o,
  input  data_t w_data_i,
  input  strb_t w_strb_i,
  // Read response channel.
  output logic  r_valid_o,
  input  logic  r_ready_i,
  output data_t r_data_o,
  output id_t   r_id_o,
  output resp_t r_resp_o,
  output logic  r_last_o,
  // Write response channel.
  output logic  b_valid_o,
  input  logic  b_ready_i,
  output id_t   b_id_o,
  output resp_t b_resp_o,
  // Memory port.
  output logic  mem_req_o,
  input  logic  mem_gnt_i,
  output addr_t mem_addr_o,
  output data_t mem_wdata_o,
  output strb_t mem_strb_o,
  output logic  mem_we_o,
  input  logic  mem_rvalid_i,
  input  data_t mem_rdata_i,
  input  logic  mem_err_i
);

  // Beat streams between the stages.
  mem_beat_if rd_beat ();
  mem_beat_if wr_beat ();
  mem_beat_if sel_beat ();

  logic rd_busy;
  logic wr_busy;

  // Read walker has no W channel.
  burst_walker #(.IS_WRITE(1'b0)) u_rd_walker (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (ar_valid_i),
    .req_ready_o (ar_ready_o),
    .req_addr_i  (ar_addr_i),
    .req_id_i    (ar_id_i),
    .req_len_i   (ar_len_i),
    .w_valid_i   (1'b0),
    .w_ready_o   (),
    .w_data_i    ('0),
    .w_strb_i    ('0),
    .busy_o      (rd_busy),
    .beat        (rd_beat)
  );

  burst_walker #(.IS_WRITE(1'b1)) u_wr_walker (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_valid_i (aw_valid_i),
    .req_ready_o (aw_ready_o),
    .req_addr_i  (aw_addr_i),
    .req_id_i    (aw_id_i),
    .req_len_i   (aw_len_i),
    .w_valid_i   (w_valid_i),
    .w_ready_o   (w_ready_o),
    .w_data_i    (w_data_i),
    .w_strb_i    (w_strb_i),
    .busy_o      (wr_busy),
    .beat        (wr_beat)
  );

  beat_arbiter u_arb (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .rd_beat   (rd_beat),
    .wr_beat   (wr_beat),
    .rd_busy_i (rd_busy),
    .wr_busy_i (wr_busy),
    .sel_beat  (sel_beat)
  );

  resp_router u_router (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .sel_beat     (sel_beat),
    .mem_req_o    (mem_req_o),
    .mem_gnt_i    (mem_gnt_i),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_strb_o   (mem_strb_o),
    .mem_we_o     (mem_we_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_err_i    (mem_err_i),
    .r_valid_o    (r_valid_o),
    .r_ready_i    (r_ready_i),
    .r_data_o     (r_data_o),
    .r_id_o       (r_id_o),
    .r_resp_o     (r_resp_o),
    .r_last_o     (r_last_o),
    .b_valid_o    (b_valid_o),
    .b_ready_i    (b_ready_i),
    .b_id_o       (b_id_o),
    .b_resp_o     (b_resp_o)
  );

endmodule

//--- verif/axi_mem_bridge_checker.sv
// Bound to axi_mem_bridge; pending accesses counted from grants and replies, assumes in-order memory.
`timescale 1ns/1ps
`include "axi_mem_cfg.svh"

module axi_mem_bridge_checker
  import axi_mem_pkg::*;
(
  input logic  clk_i,
  input logic  arst_n_i,
  input logic  r_valid_i,
  input logic  r_ready_i,
  input data_t r_data_i,
  input id_t   r_id_i,
  input resp_t r_resp_i,
  input logic  r_last_i,
  input logic  b_valid_i,
  input logic  b_ready_i,
  input id_t   b_id_i,
  input resp_t b_resp_i,
  input logic  mem_req_i,
  input logic  mem_gnt_i,
  input logic  mem_rvalid_i
);

  // Granted accesses still waiting for their memory reply.
  int unsigned pending_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= 0;
    end else begin
      pending_q <= pending_q + (mem_req_i && mem_gnt_i) - mem_rvalid_i;
    end
  end

  // A stalled R beat keeps its payload.
  r_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(r_data_i) && $stable(r_id_i)
                                && $stable(r_resp_i) && $stable(r_last_i))
    else $error("R channel changed while r_ready was low");

  // Same for B.
  b_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    b_valid_i && !b_ready_i |=> b_valid_i && $stable(b_id_i) && $stable(b_resp_i))
    else $error("B channel changed while b_ready was low");

  // Credit limit seen from the memory port.
  req_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (pending_q >= `AXM_BUF_DEPTH) |-> !mem_req_i)
    else $error("mem_req_o raised with the buffer depth already outstanding");

endmodule

bind axi_mem_bridge axi_mem_bridge_checker u_checker (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .r_valid_i    (r_valid_o),
  .r_ready_i    (r_ready_i),
  .r_data_i     (r_data_o),
  .r_id_i       (r_id_o),
  .r_resp_i     (r_resp_o),
  .r_last_i     (r_last_o),
  .b_valid_i    (b_valid_o),
  .b_ready_i    (b_ready_i),
  .b_id_i       (b_id_o),
  .b_resp_i     (b_resp_o),
  .mem_req_i    (mem_req_o),
  .mem_gnt_i    (mem_gnt_i),
  .mem_rvalid_i (mem_rvalid_i)
);

//--- verif/axi_mem_bridge_tb.sv
// Run from the project root so verif/axi_mem_golden.txt is found; memory replies two cycles after grant.
`timescale 1ns/1ps
`include "axi_mem_cfg.svh"

module axi_mem_bridge_tb
  import axi_mem_pkg::*;
();

  localparam int          NUM_LINES     = 13;
  localparam int          NUM_COLS      = 7;
  localparam int          TIMEOUT       = 500;
  localparam int          STALL_CYCLES  = 6;
  localparam int          MEM_WORDS     = 2 ** (`AXM_ADDR_W - 2);
  localparam logic [31:0] SEED          = 32'd77623;
  // Accesses at or above this byte address answer SLVERR.
  localparam addr_t       ERR_BASE      = addr_t'(16'h1000);
  // Golden op codes.
  localparam int          OP_READ       = 0;
  localparam int          OP_WRITE      = 1;
  localparam int          OP_PAR_WRITE  = 2;
  localparam int          OP_STALL_READ = 3;

  logic  clk_i = 1'b0;
  logic  arst_n_i;
  logic  ar_valid_i;
  logic  ar_ready_o;
  addr_t ar_addr_i;
  id_t   ar_id_i;
  len_t  ar_len_i;
  logic  aw_valid_i;
  logic  aw_ready_o;
  addr_t aw_addr_i;
  id_t   aw_id_i;
  len_t  aw_len_i;
  logic  w_valid_i;
  logic  w_ready_o;
  data_t w_data_i;
  strb_t w_strb_i;
  logic  r_valid_o;
  logic  r_ready_i;
  data_t r_data_o;
  id_t   r_id_o;
  resp_t r_resp_o;
  logic  r_last_o;
  logic  b_valid_o;
  logic  b_ready_i;
  id_t   b_id_o;
  resp_t b_resp_o;
  logic  mem_req_o;
  logic  mem_gnt_i;
  addr_t mem_addr_o;
  data_t mem_wdata_o;
  strb_t mem_strb_o;
  logic  mem_we_o;
  logic  mem_rvalid_i;
  data_t mem_rdata_i;
  logic  mem_err_i;

  // Memory model state.
  data_t       mem_model [MEM_WORDS];
  logic        reply_v_q;
  data_t       reply_data_q;
  logic        reply_err_q;
  logic [31:0] rng_q;
  // Forces r_ready_i low for the stall test.
  logic        hold_rready;

  logic [31:0] gold [NUM_LINES * NUM_COLS];
  int          n_checks;
  int          n_errors;
  int          n_tests;
  int          n_failed_tests;
  int          writes_done;
  int          b_seen;
  // Set once any wait ran out of cycles.
  logic        timed_out;

  axi_mem_bridge u_dut (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input strb_t strb);
    data_t res;
    res = old_w;
    for (int b = 0; b < `AXM_DATA_W / 8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Memory model with random grant and random R/B ready.
  // Reply goes out two edges after the grant edge.
  always @(posedge clk_i) begin
    logic [31:0] nxt;
    int          widx;
    nxt  = xorshift32(rng_q);
    widx = int'(mem_addr_o >> 2);
    if (arst_n_i) begin
      rng_q     <= nxt;
      mem_gnt_i <= nxt[0];
      r_ready_i <= !hold_rready && (nxt[2:1] != 2'b00);
      b_ready_i <= (nxt[4:3] != 2'b00);
      reply_v_q <= mem_req_o && mem_gnt_i;
      if (mem_req_o && mem_gnt_i) begin
        reply_err_q  <= (mem_addr_o >= ERR_BASE);
        reply_data_q <= (mem_addr_o >= ERR_BASE) ? '0 : mem_model[widx];
        // Writes past the error base are dropped.
        if (mem_we_o && mem_addr_o < ERR_BASE) begin
          mem_model[widx] <= merge_bytes(mem_model[widx], mem_wdata_o, mem_strb_o);
        end
      end
      mem_rvalid_i <= reply_v_q;
      mem_rdata_i  <= reply_data_q;
      mem_err_i    <= reply_err_q;
    end
  end

  // Counts every B handshake whether wanted or not.
  always @(posedge clk_i) begin
    if (arst_n_i && b_valid_o && b_ready_i) begin
      b_seen <= b_seen + 1;
    end
  end

  task automatic check_data(input string name, input string what, input data_t exp,
                            input data_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED %s: %s expected %h actual %h", name, what, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input string what, input resp_t exp,
                            input resp_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED %s: %s expected %0d (%s) actual %0d (%s)", name, what, exp,
               exp.name(), act, act.name());
    end
  endtask

  task automatic check_id(input string name, input string what, input id_t exp, input id_t act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED %s: %s expected %h actual %h", name, what, exp, act);
    end
  endtask

  task automatic check_last(input string name, input string what, input logic exp,
                            input logic act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAILED %s: %s expected %b actual %b", name, what, exp, act);
    end
  endtask

  task automatic check_total(input string name, input string what, input int exp, input int act);
    n_checks++;
    if (act != exp) begin
      n_errors++;
      $display("FAILED %s: %s expected %0d actual %0d", name, what, exp, act);
    end
  endtask

  task automatic finish_run();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors", n_tests,
             n_failed_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic note_timeout(input string what);
    n_errors++;
    timed_out = 1'b1;
    $display("ERROR: no progress within %0d cycles while %s", TIMEOUT, what);
  endtask

  task automatic drive_ar(input id_t id, input addr_t addr, input len_t len);
    int waited;
    waited = 0;
    @(posedge clk_i);
    ar_valid_i <= 1'b1;
    ar_addr_i  <= addr;
    ar_id_i    <= id;
    ar_len_i   <= len;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!ar_ready_o && waited <= TIMEOUT);
    ar_valid_i <= 1'b0;
    if (!ar_ready_o) begin
      note_timeout("waiting for ar_ready_o");
    end
  endtask

  // AW and the first W beat go out together.
  // Beat n carries first + n.
  task automatic drive_write(input string name, input id_t id, input addr_t addr,
                             input len_t len, input data_t first);
    int waited;
    @(posedge clk_i);
    aw_valid_i <= 1'b1;
    aw_addr_i  <= addr;
    aw_id_i    <= id;
    aw_len_i   <= len;
    w_valid_i  <= 1'b1;
    w_data_i   <= first;
    w_strb_i   <= '1;
    for (int beat = 0; beat <= int'(len); beat++) begin
      waited = 0;
      do begin
        @(posedge clk_i);
        waited++;
      end while (!w_ready_o && waited <= TIMEOUT);
      if (!w_ready_o) begin
        note_timeout("waiting for w_ready_o");
        break;
      end
      // AW is taken together with the first beat only.
      check_last(name, $sformatf("aw_ready beat %0d", beat), beat == 0, aw_ready_o);
      aw_valid_i <= 1'b0;
      w_data_i   <= first + data_t'(beat + 1);
    end
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
  endtask

  task automatic wait_b(input string name, input id_t id, input resp_t resp);
    int waited;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!(b_valid_o && b_ready_i) && waited <= TIMEOUT);
    if (!(b_valid_o && b_ready_i)) begin
      note_timeout("waiting for a B response");
    end else begin
      check_id(name, "b_id", id, b_id_o);
      check_resp(name, "b_resp", resp, b_resp_o);
      writes_done++;
    end
  endtask

  // Holds the first R beat and watches it not move.
  task automatic stall_r(input string name);
    int    waited;
    data_t data_s;
    id_t   id_s;
    resp_t resp_s;
    logic  last_s;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!r_valid_o && waited <= TIMEOUT);
    if (!r_valid_o) begin
      note_timeout("waiting for r_valid_o under stall");
    end else begin
      data_s = r_data_o;
      id_s   = r_id_o;
      resp_s = r_resp_o;
      last_s = r_last_o;
      repeat (STALL_CYCLES) begin
        @(posedge clk_i);
        check_last(name, "r_valid held", 1'b1, r_valid_o);
        check_data(name, "r_data held", data_s, r_data_o);
        check_id(name, "r_id held", id_s, r_id_o);
        check_resp(name, "r_resp held", resp_s, r_resp_o);
        check_last(name, "r_last held", last_s, r_last_o);
      end
    end
    hold_rready <= 1'b0;
  endtask

  task automatic collect_r(input string name, input id_t id, input len_t len, input data_t first,
                           input int okay_beats, input resp_t err_resp);
    int waited;
    for (int beat = 0; beat <= int'(len); beat++) begin
      waited = 0;
      do begin
        @(posedge clk_i);
        waited++;
      end while (!(r_valid_o && r_ready_i) && waited <= TIMEOUT);
      if (!(r_valid_o && r_ready_i)) begin
        note_timeout("waiting for an R beat");
        break;
      end
      // Error beats carry no meaningful data.
      if (beat < okay_beats) begin
        check_data(name, $sformatf("r_data beat %0d", beat), first + data_t'(beat), r_data_o);
        check_resp(name, "r_resp", RESP_OKAY, r_resp_o);
      end else begin
        check_resp(name, "r_resp", err_resp, r_resp_o);
      end
      check_id(name, "r_id", id, r_id_o);
      check_last(name, $sformatf("r_last beat %0d", beat), beat == int'(len), r_last_o);
    end
  endtask

  // Runs one golden line.
  task automatic run_cmd(input int base, input string name);
    int    op;
    id_t   id;
    addr_t addr;
    len_t  len;
    data_t data;
    resp_t resp;
    op   = int'(gold[base]);
    id   = id_t'(gold[base+1]);
    addr = addr_t'(gold[base+2]);
    len  = len_t'(gold[base+3]);
    data = gold[base+4];
    resp = resp_t'(gold[base+5][1:0]);
    case (op)
      OP_WRITE, OP_PAR_WRITE: begin
        drive_write(name, id, addr, len, data);
        if (!timed_out) begin
          wait_b(name, id, resp);
        end
      end
      OP_READ, OP_STALL_READ: begin
        if (op == OP_STALL_READ) begin
          hold_rready <= 1'b1;
        end
        drive_ar(id, addr, len);
        if (op == OP_STALL_READ) begin
          stall_r(name);
        end
        if (!timed_out) begin
          collect_r(name, id, len, data, int'(gold[base+6]), resp);
        end
      end
      default: begin
        n_errors++;
        $display("ERROR: %s has unknown command kind %0d", name, op);
      end
    endcase
  endtask

  initial begin
    int    ln;
    int    errs_before;
    string name;
    arst_n_i     = 1'b0;
    ar_valid_i   = 1'b0;
    ar_addr_i    = '0;
    ar_id_i      = '0;
    ar_len_i     = '0;
    aw_valid_i   = 1'b0;
    aw_addr_i    = '0;
    aw_id_i      = '0;
    aw_len_i     = '0;
    w_valid_i    = 1'b0;
    w_data_i     = '0;
    w_strb_i     = '0;
    r_ready_i    = 1'b0;
    b_ready_i    = 1'b0;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    mem_err_i    = 1'b0;
    reply_v_q    = 1'b0;
    reply_data_q = '0;
    reply_err_q  = 1'b0;
    hold_rready  = 1'b0;
    timed_out    = 1'b0;
    rng_q        = SEED;
    b_seen       = 0;
    // Fill pattern tied to the full byte address.
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_model[i] = 32'hDEAD0000 ^ data_t'(i * 4);
    end
    $readmemh("verif/axi_mem_golden.txt", gold);
    if ($isunknown(gold[0])) begin
      n_errors++;
      $display("ERROR: golden file verif/axi_mem_golden.txt did not load");
    end else begin
      repeat (5) @(posedge clk_i);
      arst_n_i <= 1'b1;
      @(posedge clk_i);
      ln = 0;
      while (ln < NUM_LINES && !timed_out) begin
        errs_before = n_errors;
        if (int'(gold[ln * NUM_COLS]) == OP_PAR_WRITE) begin
          // Write and the next line's read start on the same edge.
          name = $sformatf("line%0d_parallel", ln);
          fork
            run_cmd(ln * NUM_COLS, name);
            run_cmd((ln + 1) * NUM_COLS, name);
          join
          ln += 2;
        end else begin
          name = $sformatf("line%0d_op%0d", ln, gold[ln * NUM_COLS]);
          run_cmd(ln * NUM_COLS, name);
          ln++;
        end
        n_tests++;
        if (n_errors == errs_before) begin
          $display("test %s: ok", name);
        end else begin
          n_failed_tests++;
          $display("test %s: %0d errors", name, n_errors - errs_before);
        end
      end
      // Exactly one B per write burst.
      @(posedge clk_i);
      check_total("end", "B responses", writes_done, b_seen);
    end
    finish_run();
  end

endmodule

//--- vlog.f
+incdir+include
logic/axi_mem_pkg.sv
logic/mem_beat_if.sv
logic/sync_fifo.sv
logic/burst_walker.sv
logic/beat_arbiter.sv
logic/resp_router.sv
logic/axi_mem_bridge.sv
verif/axi_mem_bridge_checker.sv
verif/axi_mem_bridge_tb.sv

//--- verif/axi_mem_golden.txt
// Columns: op id addr len data resp okay_beats (hex). Op 0 read, 1 write, 2 write with next read, 3 stalled read.
// Beat n carries data + n; resp is B, or R past the OKAY beats; okay_beats counts leading OKAY R beats.
1 3 0040 00 11110000 0 0
0 5 0040 00 11110000 0 1
1 6 0100 03 22220000 0 0
0 7 0100 03 22220000 0 4
1 1 0ff8 03 33330000 2 0
0 2 0ff8 03 33330000 2 2
1 8 0200 07 44440000 0 0
3 9 0200 07 44440000 0 8
2 a 0300 03 55550000 0 0
0 b 0100 03 22220000 0 4
0 c 0300 03 55550000 0 4
1 d 0400 ff 66660000 0 0
0 e 0400 ff 66660000 0 100
